// File: common/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int PTCID_W     = 7;     // Instruction tag
    localparam int CACHE_LINES = 16;    // One word per line
    localparam int INDEX_W     = 4;     // Word address bits 5 to 2
    localparam int TAG_W       = ADDR_W - INDEX_W - 2;

    // REP stepping moves one 32-bit word per element
    localparam logic [ADDR_W-1:0] WORD_BYTES = 4;

    typedef enum logic [1:0] {
        OP_NONE      = 2'd0,    // No memory access, operands only
        OP_LOAD      = 2'd1,
        OP_STORE     = 2'd2,
        OP_REP_STORE = 2'd3     // Store data to count consecutive words
    } mem_op_e;

    typedef enum logic [1:0] {
        SRC_REG  = 2'd0,
        SRC_MEM  = 2'd1,        // Load data
        SRC_IMM  = 2'd2,
        SRC_ADDR = 2'd3         // Effective address
    } opsel_e;

    typedef enum logic {
        REP_IDLE = 1'b0,
        REP_RUN  = 1'b1
    } rep_state_e;

    typedef enum logic {
        C_READY = 1'b0,
        C_FILL  = 1'b1          // Waiting on fill response
    } cache_state_e;

endpackage

// File: common/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if;

    logic                          valid;
    mem_pkg::mem_op_e              op;
    logic [mem_pkg::ADDR_W-1:0]    addr;
    logic [mem_pkg::DATA_W-1:0]    wdata;
    logic [mem_pkg::PTCID_W-1:0]   ptcid;
    logic [mem_pkg::DATA_W-1:0]    reg_val;
    logic [mem_pkg::DATA_W-1:0]    imm;
    mem_pkg::opsel_e               op1_sel;
    mem_pkg::opsel_e               op2_sel;
    logic                          busy;       // Cache holds its input

    modport src (
        output valid, op, addr, wdata, ptcid, reg_val, imm, op1_sel, op2_sel,
        input  busy
    );

    modport dst (
        input  valid, op, addr, wdata, ptcid, reg_val, imm, op1_sel, op2_sel,
        output busy
    );

endinterface

// File: rep_unit/rep_addr_gen.sv
`timescale 1ns/10ps

module rep_addr_gen (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          valid_i,
    input  mem_pkg::mem_op_e              op_i,
    input  logic [mem_pkg::ADDR_W-1:0]    addr_i,
    input  logic [mem_pkg::DATA_W-1:0]    count_i,
    input  logic                          df_i,
    input  logic [mem_pkg::DATA_W-1:0]    store_data_i,
    input  logic [mem_pkg::PTCID_W-1:0]   ptcid_i,
    input  logic [mem_pkg::DATA_W-1:0]    reg_val_i,
    input  logic [mem_pkg::DATA_W-1:0]    imm_i,
    input  mem_pkg::opsel_e               op1_sel_i,
    input  mem_pkg::opsel_e               op2_sel_i,
    output logic                          stall_o,
    mem_req_if.src                        req
);

    mem_pkg::rep_state_e          state_q;
    logic [mem_pkg::DATA_W-1:0]   rem_q;
    logic                         df_q;
    logic [mem_pkg::ADDR_W-1:0]   next_addr;
    logic                         accept;
    logic                         is_rep;
    logic                         advance;

    assign is_rep  = (op_i == mem_pkg::OP_REP_STORE);
    assign stall_o = req.busy || (state_q == mem_pkg::REP_RUN);
    assign accept  = valid_i && !stall_o;
    assign advance = (state_q == mem_pkg::REP_RUN) && !req.busy;    // Next REP element

    assign next_addr = df_q ? (req.addr - mem_pkg::WORD_BYTES)
                            : (req.addr + mem_pkg::WORD_BYTES);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= mem_pkg::REP_IDLE;
            rem_q     <= '0;
            req.valid <= 1'b0;
        end else if (!req.busy) begin
            if (state_q == mem_pkg::REP_RUN) begin
                rem_q <= rem_q - 1'b1;
                if (rem_q == 1) begin
                    state_q <= mem_pkg::REP_IDLE;    // Last element now in request
                end
            end else if (accept) begin
                req.valid <= !(is_rep && (count_i == '0));    // REP of zero issues nothing
                if (is_rep && (count_i > 1)) begin
                    state_q <= mem_pkg::REP_RUN;
                    rem_q   <= count_i - 1'b1;
                end
            end else begin
                req.valid <= 1'b0;    // Taken by cache, nothing new
            end
        end
    end

    // Request fields only change when the cache is free to take them
    always_ff @(posedge clk) begin
        if (advance) begin
            req.addr <= next_addr;
        end else if (accept) begin
            req.op      <= op_i;
            req.addr    <= addr_i;
            req.wdata   <= store_data_i;
            req.ptcid   <= ptcid_i;
            req.reg_val <= reg_val_i;
            req.imm     <= imm_i;
            req.op1_sel <= op1_sel_i;
            req.op2_sel <= op2_sel_i;
            df_q        <= df_i;
        end
    end

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n_i,
    mem_req_if.dst                        req,
    output logic                          fill_req_o,
    output logic [mem_pkg::ADDR_W-1:0]    fill_addr_o,
    input  logic                          fill_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]    fill_data_i,
    output logic                          mem_wr_o,
    output logic [mem_pkg::ADDR_W-1:0]    mem_wr_addr_o,
    output logic [mem_pkg::DATA_W-1:0]    mem_wr_data_o,
    output logic                          res_valid_o,
    output logic [mem_pkg::DATA_W-1:0]    res_data_o,
    output logic [mem_pkg::ADDR_W-1:0]    res_addr_o,
    output logic [mem_pkg::PTCID_W-1:0]   res_ptcid_o,
    output logic [mem_pkg::DATA_W-1:0]    res_reg_o,
    output logic [mem_pkg::DATA_W-1:0]    res_imm_o,
    output mem_pkg::opsel_e               res_op1_sel_o,
    output mem_pkg::opsel_e               res_op2_sel_o
);

    mem_pkg::cache_state_e             state_q;
    logic [mem_pkg::CACHE_LINES-1:0]   line_valid_q;
    logic [mem_pkg::TAG_W-1:0]         tag_q  [mem_pkg::CACHE_LINES];
    logic [mem_pkg::DATA_W-1:0]        data_q [mem_pkg::CACHE_LINES];
    logic [mem_pkg::INDEX_W-1:0]       req_idx;
    logic [mem_pkg::TAG_W-1:0]         req_tag;
    logic [mem_pkg::INDEX_W-1:0]       fill_idx;
    logic [mem_pkg::TAG_W-1:0]         fill_tag;
    logic                              hit;
    logic                              take;
    logic                              is_load;
    logic                              is_store;
    logic                              fill_done;

    assign req_idx  = req.addr[mem_pkg::INDEX_W+1:2];
    assign req_tag  = req.addr[mem_pkg::ADDR_W-1:mem_pkg::INDEX_W+2];
    assign fill_idx = res_addr_o[mem_pkg::INDEX_W+1:2];    // Miss address held in result reg
    assign fill_tag = res_addr_o[mem_pkg::ADDR_W-1:mem_pkg::INDEX_W+2];

    assign hit = line_valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign is_load  = (req.op == mem_pkg::OP_LOAD);
    assign is_store = (req.op == mem_pkg::OP_STORE) || (req.op == mem_pkg::OP_REP_STORE);

    assign req.busy  = (state_q == mem_pkg::C_FILL);
    assign take      = req.valid && (state_q == mem_pkg::C_READY);
    assign fill_done = (state_q == mem_pkg::C_FILL) && fill_valid_i;

    // Write port and fill address reuse the result registers
    assign fill_addr_o   = res_addr_o;
    assign mem_wr_addr_o = res_addr_o;
    assign mem_wr_data_o = res_data_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= mem_pkg::C_READY;
            line_valid_q <= '0;
            fill_req_o   <= 1'b0;
            mem_wr_o     <= 1'b0;
            res_valid_o  <= 1'b0;
        end else begin
            res_valid_o <= 1'b0;
            mem_wr_o    <= 1'b0;
            if (state_q == mem_pkg::C_READY) begin
                if (take && is_load && !hit) begin
                    state_q    <= mem_pkg::C_FILL;
                    fill_req_o <= 1'b1;
                end else if (take) begin
                    res_valid_o <= 1'b1;
                    mem_wr_o    <= is_store;    // Write-through on every store
                end
            end else if (fill_valid_i) begin
                state_q                <= mem_pkg::C_READY;
                fill_req_o             <= 1'b0;
                res_valid_o            <= 1'b1;
                line_valid_q[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_addr_o    <= req.addr;
            res_ptcid_o   <= req.ptcid;
            res_reg_o     <= req.reg_val;
            res_imm_o     <= req.imm;
            res_op1_sel_o <= req.op1_sel;
            res_op2_sel_o <= req.op2_sel;
            if (is_load) begin
                res_data_o <= data_q[req_idx];    // Replaced by fill data on a miss
            end else if (is_store) begin
                res_data_o <= req.wdata;
            end else begin
                res_data_o <= '0;
            end
            if (is_store && hit) begin
                data_q[req_idx] <= req.wdata;    // No allocate on store miss
            end
        end else if (fill_done) begin
            res_data_o       <= fill_data_i;
            data_q[fill_idx] <= fill_data_i;
            tag_q[fill_idx]  <= fill_tag;
        end
    end

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/10ps

module operand_select (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          res_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]    res_data_i,
    input  logic [mem_pkg::ADDR_W-1:0]    res_addr_i,
    input  logic [mem_pkg::PTCID_W-1:0]   res_ptcid_i,
    input  logic [mem_pkg::DATA_W-1:0]    res_reg_i,
    input  logic [mem_pkg::DATA_W-1:0]    res_imm_i,
    input  mem_pkg::opsel_e               res_op1_sel_i,
    input  mem_pkg::opsel_e               res_op2_sel_i,
    output logic                          out_valid_o,
    output logic [mem_pkg::PTCID_W-1:0]   out_ptcid_o,
    output logic [mem_pkg::ADDR_W-1:0]    out_addr_o,
    output logic [mem_pkg::DATA_W-1:0]    op1_o,
    output logic [mem_pkg::DATA_W-1:0]    op2_o
);

    logic [mem_pkg::DATA_W-1:0] op1_d;
    logic [mem_pkg::DATA_W-1:0] op2_d;

    function automatic logic [mem_pkg::DATA_W-1:0] pick_operand(
        input mem_pkg::opsel_e               sel,
        input logic [mem_pkg::DATA_W-1:0]    reg_val,
        input logic [mem_pkg::DATA_W-1:0]    mem_data,
        input logic [mem_pkg::DATA_W-1:0]    imm,
        input logic [mem_pkg::ADDR_W-1:0]    addr
    );
        logic [mem_pkg::DATA_W-1:0] val;
        case (sel)
            mem_pkg::SRC_REG:  val = reg_val;
            mem_pkg::SRC_MEM:  val = mem_data;
            mem_pkg::SRC_IMM:  val = imm;
            mem_pkg::SRC_ADDR: val = addr;
            default:           val = reg_val;
        endcase
        return val;
    endfunction

    assign op1_d = pick_operand(res_op1_sel_i, res_reg_i, res_data_i, res_imm_i, res_addr_i);
    assign op2_d = pick_operand(res_op2_sel_i, res_reg_i, res_data_i, res_imm_i, res_addr_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= res_valid_i;
        end
    end

    // Operands hold between results
    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            out_ptcid_o <= res_ptcid_i;
            out_addr_o  <= res_addr_i;
            op1_o       <= op1_d;
            op2_o       <= op2_d;
        end
    end

endmodule

// File: hdl/mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          valid_i,
    input  mem_pkg::mem_op_e              op_i,
    input  logic [mem_pkg::ADDR_W-1:0]    addr_i,
    input  logic [mem_pkg::DATA_W-1:0]    count_i,
    input  logic                          df_i,
    input  logic [mem_pkg::DATA_W-1:0]    store_data_i,
    input  logic [mem_pkg::DATA_W-1:0]    reg_val_i,
    input  logic [mem_pkg::DATA_W-1:0]    imm_i,
    input  mem_pkg::opsel_e               op1_sel_i,
    input  mem_pkg::opsel_e               op2_sel_i,
    input  logic [mem_pkg::PTCID_W-1:0]   ptcid_i,
    output logic                          stall_o,
    output logic                          fill_req_o,
    output logic [mem_pkg::ADDR_W-1:0]    fill_addr_o,
    input  logic                          fill_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]    fill_data_i,
    output logic                          mem_wr_o,
    output logic [mem_pkg::ADDR_W-1:0]    mem_wr_addr_o,
    output logic [mem_pkg::DATA_W-1:0]    mem_wr_data_o,
    output logic                          out_valid_o,
    output logic [mem_pkg::PTCID_W-1:0]   out_ptcid_o,
    output logic [mem_pkg::ADDR_W-1:0]    out_addr_o,
    output logic [mem_pkg::DATA_W-1:0]    op1_o,
    output logic [mem_pkg::DATA_W-1:0]    op2_o
);

    logic                          res_valid;
    logic [mem_pkg::DATA_W-1:0]    res_data;
    logic [mem_pkg::ADDR_W-1:0]    res_addr;
    logic [mem_pkg::PTCID_W-1:0]   res_ptcid;
    logic [mem_pkg::DATA_W-1:0]    res_reg;
    logic [mem_pkg::DATA_W-1:0]    res_imm;
    mem_pkg::opsel_e               res_op1_sel;
    mem_pkg::opsel_e               res_op2_sel;

    mem_req_if req_if ();

    rep_addr_gen i_rep_addr_gen (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .count_i      (count_i),
        .df_i         (df_i),
        .store_data_i (store_data_i),
        .ptcid_i      (ptcid_i),
        .reg_val_i    (reg_val_i),
        .imm_i        (imm_i),
        .op1_sel_i    (op1_sel_i),
        .op2_sel_i    (op2_sel_i),
        .stall_o      (stall_o),
        .req          (req_if.src)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req           (req_if.dst),
        .fill_req_o    (fill_req_o),
        .fill_addr_o   (fill_addr_o),
        .fill_valid_i  (fill_valid_i),
        .fill_data_i   (fill_data_i),
        .mem_wr_o      (mem_wr_o),
        .mem_wr_addr_o (mem_wr_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .res_valid_o   (res_valid),
        .res_data_o    (res_data),
        .res_addr_o    (res_addr),
        .res_ptcid_o   (res_ptcid),
        .res_reg_o     (res_reg),
        .res_imm_o     (res_imm),
        .res_op1_sel_o (res_op1_sel),
        .res_op2_sel_o (res_op2_sel)
    );

    operand_select i_operand_select (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .res_valid_i   (res_valid),
        .res_data_i    (res_data),
        .res_addr_i    (res_addr),
        .res_ptcid_i   (res_ptcid),
        .res_reg_i     (res_reg),
        .res_imm_i     (res_imm),
        .res_op1_sel_i (res_op1_sel),
        .res_op2_sel_i (res_op2_sel),
        .out_valid_o   (out_valid_o),
        .out_ptcid_o   (out_ptcid_o),
        .out_addr_o    (out_addr_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o)
    );

endmodule

// File: verification/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;

    localparam int NUM_STEPS = 16;
    localparam int MAX_ELEM  = 8;
    localparam int TIMEOUT   = 50;     // Cycles per wait
    localparam int SETTLE    = 4;      // Quiet window after each step

    typedef struct packed {
        mem_pkg::mem_op_e            op;
        logic [mem_pkg::ADDR_W-1:0]  addr;
        logic [mem_pkg::DATA_W-1:0]  count;
        logic                        df;
        logic [mem_pkg::DATA_W-1:0]  sdata;
        logic [mem_pkg::DATA_W-1:0]  regv;
        logic [mem_pkg::DATA_W-1:0]  imm;
        mem_pkg::opsel_e             s1;
        mem_pkg::opsel_e             s2;
        logic [7:0]                  n_res;    // Expected results
    } step_t;

    logic                          clk = 1'b0;
    logic                          rst_n_i;
    logic                          valid_i;
    mem_pkg::mem_op_e              op_i;
    logic [mem_pkg::ADDR_W-1:0]    addr_i;
    logic [mem_pkg::DATA_W-1:0]    count_i;
    logic                          df_i;
    logic [mem_pkg::DATA_W-1:0]    store_data_i;
    logic [mem_pkg::DATA_W-1:0]    reg_val_i;
    logic [mem_pkg::DATA_W-1:0]    imm_i;
    mem_pkg::opsel_e               op1_sel_i;
    mem_pkg::opsel_e               op2_sel_i;
    logic [mem_pkg::PTCID_W-1:0]   ptcid_i;
    logic                          stall_o;
    logic                          fill_req_o;
    logic [mem_pkg::ADDR_W-1:0]    fill_addr_o;
    logic                          fill_valid_i;
    logic [mem_pkg::DATA_W-1:0]    fill_data_i;
    logic                          mem_wr_o;
    logic [mem_pkg::ADDR_W-1:0]    mem_wr_addr_o;
    logic [mem_pkg::DATA_W-1:0]    mem_wr_data_o;
    logic                          out_valid_o;
    logic [mem_pkg::PTCID_W-1:0]   out_ptcid_o;
    logic [mem_pkg::ADDR_W-1:0]    out_addr_o;
    logic [mem_pkg::DATA_W-1:0]    op1_o;
    logic [mem_pkg::DATA_W-1:0]    op2_o;

    step_t                         steps [NUM_STEPS];
    logic [mem_pkg::DATA_W-1:0]    mem_model [64];
    logic [mem_pkg::DATA_W-1:0]    ref_mem [64];     // Predicted memory contents
    logic                          ref_valid [mem_pkg::CACHE_LINES];
    logic [mem_pkg::TAG_W-1:0]     ref_tag [mem_pkg::CACHE_LINES];
    logic [mem_pkg::ADDR_W-1:0]    exp_addr [MAX_ELEM];
    logic [mem_pkg::DATA_W-1:0]    exp_op1 [MAX_ELEM];
    logic [mem_pkg::DATA_W-1:0]    exp_op2 [MAX_ELEM];
    logic [mem_pkg::DATA_W-1:0]    exp_wdata;
    logic [mem_pkg::ADDR_W-1:0]    fill_last_addr;
    int                            exp_res_n;
    int                            exp_wr_n;
    int                            res_idx;
    int                            wr_idx;
    int                            cur_step;
    int                            step_cyc;
    logic                          lat_check;
    int                            fill_cnt = 0;
    int                            err_cnt = 0;
    int                            timeout_cnt = 0;

    mem_stage_top i_mem_stage_top (.*);

    always #50 clk = ~clk;

    function automatic logic [mem_pkg::DATA_W-1:0] init_word(input int i);
        return 32'h3C5A_0000 ^ (32'(i) * 32'h01F0_0E1B) ^ 32'(i);
    endfunction

    function automatic step_t make_step(
        input mem_pkg::mem_op_e op, input logic [31:0] addr, input logic [31:0] count,
        input logic df, input logic [31:0] sdata, input logic [31:0] regv,
        input logic [31:0] imm, input mem_pkg::opsel_e s1, input mem_pkg::opsel_e s2,
        input int n_res
    );
        step_t st;
        st = '{op, addr, count, df, sdata, regv, imm, s1, s2, 8'(n_res)};
        return st;
    endfunction

    task automatic check_data(input logic [mem_pkg::DATA_W-1:0] exp,
                              input logic [mem_pkg::DATA_W-1:0] got, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_addr(input logic [mem_pkg::ADDR_W-1:0] exp,
                              input logic [mem_pkg::ADDR_W-1:0] got, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_tag(input logic [mem_pkg::PTCID_W-1:0] exp,
                             input logic [mem_pkg::PTCID_W-1:0] got, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic load_table();
        steps[0]  = make_step(mem_pkg::OP_LOAD, 32'h010, 0, 0, 0, 32'h1111_0000, 32'h2222_0000,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_REG, 1);     // Cold miss
        steps[1]  = make_step(mem_pkg::OP_LOAD, 32'h010, 0, 0, 0, 32'h1111_0001, 32'h2222_0001,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_IMM, 1);     // Hit
        steps[2]  = make_step(mem_pkg::OP_STORE, 32'h010, 0, 0, 32'hDEAD_0010, 32'h1111_0002,
                              32'h2222_0002, mem_pkg::SRC_MEM, mem_pkg::SRC_ADDR, 1);
        steps[3]  = make_step(mem_pkg::OP_LOAD, 32'h010, 0, 0, 0, 32'h1111_0003, 32'h2222_0003,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_REG, 1);
        steps[4]  = make_step(mem_pkg::OP_STORE, 32'h024, 0, 0, 32'h0BEE_0024, 32'h1111_0004,
                              32'h2222_0004, mem_pkg::SRC_REG, mem_pkg::SRC_MEM, 1);    // No allocate
        steps[5]  = make_step(mem_pkg::OP_LOAD, 32'h024, 0, 0, 0, 32'h1111_0005, 32'h2222_0005,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_IMM, 1);
        steps[6]  = make_step(mem_pkg::OP_REP_STORE, 32'h040, 4, 0, 32'h5EED_0040, 32'h1111_0006,
                              32'h2222_0006, mem_pkg::SRC_ADDR, mem_pkg::SRC_MEM, 4);
        steps[7]  = make_step(mem_pkg::OP_REP_STORE, 32'h0A0, 3, 1, 32'h5EED_00A0, 32'h1111_0007,
                              32'h2222_0007, mem_pkg::SRC_ADDR, mem_pkg::SRC_REG, 3);
        steps[8]  = make_step(mem_pkg::OP_REP_STORE, 32'h080, 0, 0, 32'h5EED_0080, 32'h1111_0008,
                              32'h2222_0008, mem_pkg::SRC_ADDR, mem_pkg::SRC_MEM, 0);
        steps[9]  = make_step(mem_pkg::OP_NONE, 32'h0C8, 0, 0, 0, 32'h1111_0009, 32'h2222_0009,
                              mem_pkg::SRC_REG, mem_pkg::SRC_IMM, 1);
        steps[10] = make_step(mem_pkg::OP_LOAD, 32'h0C8, 0, 0, 0, 32'h1111_000A, 32'h2222_000A,
                              mem_pkg::SRC_ADDR, mem_pkg::SRC_IMM, 1);
        steps[11] = make_step(mem_pkg::OP_LOAD, 32'h050, 0, 0, 0, 32'h1111_000B, 32'h2222_000B,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_REG, 1);     // Same index as 0x010
        steps[12] = make_step(mem_pkg::OP_LOAD, 32'h010, 0, 0, 0, 32'h1111_000C, 32'h2222_000C,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_REG, 1);
        steps[13] = make_step(mem_pkg::OP_LOAD, 32'h098, 0, 0, 0, 32'h1111_000D, 32'h2222_000D,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_ADDR, 1);
        steps[14] = make_step(mem_pkg::OP_REP_STORE, 32'h010, 1, 0, 32'h600D_0010, 32'h1111_000E,
                              32'h2222_000E, mem_pkg::SRC_MEM, mem_pkg::SRC_ADDR, 1);
        steps[15] = make_step(mem_pkg::OP_LOAD, 32'h010, 0, 0, 0, 32'h1111_000F, 32'h2222_000F,
                              mem_pkg::SRC_MEM, mem_pkg::SRC_REG, 1);
    endtask

    // Called once per falling edge while a step is in flight
    task automatic sample_outputs();
        if (mem_wr_o) begin
            if (wr_idx < exp_wr_n) begin
                check_addr(exp_addr[wr_idx], mem_wr_addr_o,
                           $sformatf("step %0d write %0d address", cur_step, wr_idx));
                check_data(exp_wdata, mem_wr_data_o,
                           $sformatf("step %0d write %0d data", cur_step, wr_idx));
            end else begin
                err_cnt++;
                $display("Step %0d: memory write pulse that no store asked for", cur_step);
            end
            wr_idx++;
        end
        if (out_valid_o) begin
            if (res_idx < exp_res_n) begin
                if (res_idx == 0 && lat_check) begin
                    check_data(32'd3, 32'(step_cyc), $sformatf("step %0d hit latency", cur_step));
                end
                check_tag(7'(cur_step), out_ptcid_o, $sformatf("step %0d ptcid", cur_step));
                check_addr(exp_addr[res_idx], out_addr_o,
                           $sformatf("step %0d result %0d address", cur_step, res_idx));
                check_data(exp_op1[res_idx], op1_o,
                           $sformatf("step %0d result %0d op1", cur_step, res_idx));
                check_data(exp_op2[res_idx], op2_o,
                           $sformatf("step %0d result %0d op2", cur_step, res_idx));
            end else begin
                err_cnt++;
                $display("Step %0d: a result came out that was not expected", cur_step);
            end
            res_idx++;
        end
    endtask

    task automatic run_step(input int s);
        step_t                       st;
        logic [mem_pkg::ADDR_W-1:0]  a;
        logic [mem_pkg::DATA_W-1:0]  memv;
        logic [mem_pkg::DATA_W-1:0]  cand [4];
        logic [3:0]                  idx;
        logic                        exp_fill;
        int                          fills_before;
        int                          wait_cnt;
        st        = steps[s];
        cur_step  = s;
        exp_res_n = int'(st.n_res);
        exp_fill  = 1'b0;
        exp_wdata = st.sdata;
        exp_wr_n  = (st.op == mem_pkg::OP_STORE || st.op == mem_pkg::OP_REP_STORE) ? exp_res_n : 0;
        for (int e = 0; e < exp_res_n; e++) begin
            a = st.addr;
            if (st.op == mem_pkg::OP_REP_STORE) begin
                a = st.df ? st.addr - 32'(4 * e) : st.addr + 32'(4 * e);
            end
            idx  = a[5:2];
            memv = '0;
            if (st.op == mem_pkg::OP_LOAD) begin
                memv = ref_mem[a[7:2]];
                if (!(ref_valid[idx] && ref_tag[idx] == a[31:6])) begin
                    exp_fill       = 1'b1;    // Miss installs the line
                    ref_valid[idx] = 1'b1;
                    ref_tag[idx]   = a[31:6];
                end
            end else if (exp_wr_n != 0) begin
                memv           = st.sdata;
                ref_mem[a[7:2]] = st.sdata;
            end
            cand[0]     = st.regv;
            cand[1]     = memv;
            cand[2]     = st.imm;
            cand[3]     = a;
            exp_addr[e] = a;
            exp_op1[e]  = cand[st.s1];
            exp_op2[e]  = cand[st.s2];
        end
        lat_check = (st.op == mem_pkg::OP_LOAD) && !exp_fill;
        res_idx   = 0;
        wr_idx    = 0;

        @(negedge clk);
        fills_before = fill_cnt;
        op_i         = st.op;
        addr_i       = st.addr;
        count_i      = st.count;
        df_i         = st.df;
        store_data_i = st.sdata;
        reg_val_i    = st.regv;
        imm_i        = st.imm;
        op1_sel_i    = st.s1;
        op2_sel_i    = st.s2;
        ptcid_i      = 7'(s);
        valid_i      = 1'b1;
        wait_cnt     = 0;
        while (stall_o && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (stall_o) begin
            timeout_cnt++;
            valid_i = 1'b0;
            $display("Timeout at %0t: step %0d never saw stall_o drop", $time, s);
            return;
        end
        @(negedge clk);
        valid_i  = 1'b0;    // Taken on the last rising edge
        step_cyc = 1;
        sample_outputs();
        wait_cnt = 0;
        while (res_idx < exp_res_n && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            step_cyc++;
            wait_cnt++;
            sample_outputs();
        end
        if (res_idx < exp_res_n) begin
            timeout_cnt++;
            $display("Timeout at %0t: step %0d got %0d of %0d results", $time, s, res_idx,
                     exp_res_n);
            return;
        end
        for (int k = 0; k < SETTLE; k++) begin
            @(negedge clk);
            step_cyc++;
            sample_outputs();
            if (st.op == mem_pkg::OP_REP_STORE && st.count == 0 && stall_o) begin
                err_cnt++;
                $display("Step %0d: a REP store with count zero raised stall_o", s);
            end
        end
        check_data(32'(exp_wr_n), 32'(wr_idx), $sformatf("step %0d write count", s));
        check_data(32'(exp_fill), 32'(fill_cnt - fills_before),
                   $sformatf("step %0d fill count", s));
        if (exp_fill) begin
            check_addr(st.addr, fill_last_addr, $sformatf("step %0d fill address", s));
        end
    endtask

    // Memory write port
    initial begin : write_port
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = init_word(i);
        end
        forever begin
            @(negedge clk);
            if (mem_wr_o) begin
                mem_model[mem_wr_addr_o[7:2]] = mem_wr_data_o;
            end
        end
    end

    // Fill responder, answers after 1 to 4 cycles
    initial begin : fill_port
        int unsigned delay;
        void'($urandom(78));
        fill_valid_i = 1'b0;
        fill_data_i  = '0;
        forever begin
            @(negedge clk);
            if (fill_req_o && rst_n_i) begin
                fill_cnt++;
                fill_last_addr = fill_addr_o;
                delay = 1 + ($urandom % 4);
                repeat (delay) @(negedge clk);
                fill_data_i  = mem_model[fill_last_addr[7:2]];
                fill_valid_i = 1'b1;
                @(negedge clk);
                fill_valid_i = 1'b0;
            end
        end
    end

    initial begin
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        op_i         = mem_pkg::OP_NONE;
        addr_i       = '0;
        count_i      = '0;
        df_i         = 1'b0;
        store_data_i = '0;
        reg_val_i    = '0;
        imm_i        = '0;
        op1_sel_i    = mem_pkg::SRC_REG;
        op2_sel_i    = mem_pkg::SRC_REG;
        ptcid_i      = '0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = init_word(i);
        end
        for (int i = 0; i < mem_pkg::CACHE_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_data(32'h0, 32'({out_valid_o, fill_req_o, mem_wr_o, stall_o}),
                   "control outputs after reset");
        for (int s = 0; s < NUM_STEPS; s++) begin
            run_step(s);
            if (timeout_cnt != 0) begin
                break;
            end
        end
        $display("Checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
common/mem_pkg.sv
common/mem_req_if.sv
rep_unit/rep_addr_gen.sv
dcache/dcache_ctrl.sv
hdl/operand_select.sv
hdl/mem_stage_top.sv
verification/tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mem_stage -f flist.f -o tb_mem_stage
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_mem_stage)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST OK$"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
